// File: include/pipeline_consts.svh
//////////////////////////////////////////////////
// Pipeline constants
// Strand, register and lane geometry shared by the
// register operand block
//////////////////////////////////////////////////

`ifndef PIPELINE_CONSTS_SVH
`define PIPELINE_CONSTS_SVH

// Hardware strands sharing the register files
`define NUM_STRANDS 4

// Architectural registers seen by one strand
`define REGS_PER_STRAND 32

// Lanes in one vector register
`define NUM_LANES 16
`define LANE_WIDTH 32	// Bits per lane, also the scalar width

`endif

// File: src/reg_pkg.sv
//////////////////////////////////////////////////
// Register types
// Register addressing and the scalar and vector
// data words held by the register files
//////////////////////////////////////////////////

`include "pipeline_consts.svh"

package reg_pkg;

	typedef logic [$clog2(`NUM_STRANDS)-1:0] strand_t;	// Strand number
	typedef logic [$clog2(`REGS_PER_STRAND)-1:0] reg_index_t;	// Register within strand

	// Storage address, strand in the upper bits
	typedef struct packed
	{
		strand_t strand;
		reg_index_t index;
	} reg_addr_t;

	typedef logic [`LANE_WIDTH-1:0] scalar_t;	// One lane or one scalar
	typedef logic [`NUM_LANES-1:0] lane_mask_t;	// Write enable per lane

	// Full vector register
	// Flat view moves the data, lane view serves merges and broadcast
	typedef union packed
	{
		logic [`NUM_LANES*`LANE_WIDTH-1:0] bits;
		scalar_t [`NUM_LANES-1:0] lanes;
	} vector_word_u;

endpackage

// File: src/port_pkg.sv
//////////////////////////////////////////////////
// Port bundles
// Read request, writeback and operand result
// structs at the boundary of the operand block
//////////////////////////////////////////////////

package port_pkg;

	// Operand read request from the issue side
	typedef struct packed
	{
		logic valid;	// Request present this cycle
		reg_pkg::strand_t strand;	// Strand owning both operands
		reg_pkg::reg_index_t sel1;	// First operand register
		reg_pkg::reg_index_t sel2;	// Second operand register
		logic op1_is_vector;	// Operand 1 from vector file
		logic op2_is_vector;	// Operand 2 from vector file
	} read_req_t;

	// Result written back into one of the files
	// Scalar writes take lane 0 of value and ignore mask
	typedef struct packed
	{
		logic valid;
		logic is_vector;	// Selects the target file
		reg_pkg::reg_addr_t addr;	// Strand and register
		reg_pkg::vector_word_u value;
		reg_pkg::lane_mask_t mask;	// Vector lanes to update
	} writeback_t;

	// Operands handed to the consumer, one cycle after the request
	typedef struct packed
	{
		logic valid;
		reg_pkg::vector_word_u op1;	// Scalars already replicated
		reg_pkg::vector_word_u op2;
	} operand_t;

endpackage

// File: src/scalar_register_file.sv
//////////////////////////////////////////////////
// Scalar register file
// One 32-bit word per register for every strand,
// two registered reads and one write per cycle
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "pipeline_consts.svh"

module scalar_register_file
(
	input logic clk,
	input reg_pkg::strand_t strand,
	input reg_pkg::reg_index_t sel1,
	input reg_pkg::reg_index_t sel2,
	input port_pkg::writeback_t writeback,
	output reg_pkg::scalar_t value1,
	output reg_pkg::scalar_t value2
);

	// No reset on contents, undefined until written
	reg_pkg::scalar_t registers[`NUM_STRANDS*`REGS_PER_STRAND];

	reg_pkg::reg_addr_t read_addr1;
	reg_pkg::reg_addr_t read_addr2;
	logic write_en;

	assign read_addr1 = '{strand: strand, index: sel1};	// Same strand for both ports
	assign read_addr2 = '{strand: strand, index: sel2};

	// Vector writebacks belong to the other file
	assign write_en = writeback.valid && !writeback.is_vector;

	// Reads see the old word on a same-edge write
	always_ff @(posedge clk)
	begin
		value1 <= registers[read_addr1];
		value2 <= registers[read_addr2];

		if (write_en)
		begin
			registers[writeback.addr] <= writeback.value.lanes[0];	// Lane 0 carries scalar
		end
	end

endmodule

// File: src/vector_register_file.sv
//////////////////////////////////////////////////
// Vector register file
// Sixteen 32-bit lanes per register, two registered
// reads and one lane-masked write per cycle
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "pipeline_consts.svh"

module vector_register_file
(
	input logic clk,
	input reg_pkg::strand_t strand,
	input reg_pkg::reg_index_t sel1,
	input reg_pkg::reg_index_t sel2,
	input port_pkg::writeback_t writeback,
	output reg_pkg::vector_word_u value1,
	output reg_pkg::vector_word_u value2
);

	// Contents undefined until written
	reg_pkg::vector_word_u registers[`NUM_STRANDS*`REGS_PER_STRAND];

	reg_pkg::reg_addr_t read_addr1;
	reg_pkg::reg_addr_t read_addr2;
	logic write_en;

	assign read_addr1 = '{strand: strand, index: sel1};
	assign read_addr2 = '{strand: strand, index: sel2};

	// Only vector writebacks land here
	assign write_en = writeback.valid && writeback.is_vector;

	// Registered read ports
	// A same-edge write is not visible until the next read
	always_ff @(posedge clk)
	begin
		value1 <= registers[read_addr1];
		value2 <= registers[read_addr2];
	end

	// Lane-masked write
	// Disabled lanes keep their previous contents
	always_ff @(posedge clk)
	begin
		if (write_en)
		begin
			for (int lane = 0; lane < `NUM_LANES; lane++)
			begin
				if (writeback.mask[lane])
				begin
					registers[writeback.addr].lanes[lane] <=
						writeback.value.lanes[lane];	// One lane per mask bit
				end
			end
		end
	end

endmodule

// File: src/operand_bypass.sv
//////////////////////////////////////////////////
// Operand bypass
// Repairs stale file reads with the delayed last
// writeback and forms the two vector operands
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "pipeline_consts.svh"

module operand_bypass
(
	input logic clk,
	input logic reset,
	input port_pkg::read_req_t read_req,
	input port_pkg::writeback_t writeback,
	input reg_pkg::scalar_t scalar1,
	input reg_pkg::scalar_t scalar2,
	input reg_pkg::vector_word_u vector1,
	input reg_pkg::vector_word_u vector2,
	output port_pkg::operand_t operands
);

	port_pkg::read_req_t req_l;	// Request aligned with file outputs
	port_pkg::writeback_t wb_l;	// Writeback from the read edge
	reg_pkg::reg_addr_t addr1;
	reg_pkg::reg_addr_t addr2;

	// Overlay written lanes on the word read from the file
	function automatic reg_pkg::vector_word_u merge_lanes(
		input reg_pkg::vector_word_u file_word,
		input reg_pkg::vector_word_u written,
		input reg_pkg::lane_mask_t mask);
		reg_pkg::vector_word_u merged;

		merged = file_word;
		for (int lane = 0; lane < `NUM_LANES; lane++)
		begin
			if (mask[lane])
				merged.lanes[lane] = written.lanes[lane];
		end
		return merged;
	endfunction

	// Scalar copied into every lane
	function automatic reg_pkg::vector_word_u broadcast(input reg_pkg::scalar_t value);
		reg_pkg::vector_word_u word;

		for (int lane = 0; lane < `NUM_LANES; lane++)
			word.lanes[lane] = value;
		return word;
	endfunction

	// One operand slot
	// Bypass both kinds, then pick by the slot's flag
	function automatic reg_pkg::vector_word_u form_operand(
		input logic is_vector,
		input reg_pkg::reg_addr_t addr,
		input reg_pkg::scalar_t scalar_word,
		input reg_pkg::vector_word_u vector_word,
		input port_pkg::writeback_t wb);
		logic hit;
		reg_pkg::scalar_t scalar_value;
		reg_pkg::vector_word_u vector_value;

		hit = wb.valid && (wb.addr == addr);	// Kind checked below
		scalar_value = (hit && !wb.is_vector) ? wb.value.lanes[0] : scalar_word;
		vector_value = (hit && wb.is_vector)
			? merge_lanes(vector_word, wb.value, wb.mask) : vector_word;
		return is_vector ? vector_value : broadcast(scalar_value);
	endfunction

	// Latch at the same edge the files read
	// Reset clears only the strobes
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			req_l.valid <= 1'b0;
			wb_l.valid <= 1'b0;
		end
		else
		begin
			req_l <= read_req;
			wb_l <= writeback;	// Missed by the file read this edge
		end
	end

	assign addr1 = '{strand: req_l.strand, index: req_l.sel1};
	assign addr2 = '{strand: req_l.strand, index: req_l.sel2};

	// Combinational repair, no extra cycle
	always_comb
	begin
		operands.valid = req_l.valid;
		operands.op1 = form_operand(req_l.op1_is_vector, addr1, scalar1, vector1, wb_l);
		operands.op2 = form_operand(req_l.op2_is_vector, addr2, scalar2, vector2, wb_l);
	end

endmodule

// File: src/register_operand_unit.sv
//////////////////////////////////////////////////
// Register operand unit
// Scalar and vector register files with the operand
// bypass, one-cycle request to operand latency
//////////////////////////////////////////////////

`timescale 1ns/1ns

module register_operand_unit
(
	input logic clk,
	input logic reset,
	input port_pkg::read_req_t read_req,
	input port_pkg::writeback_t writeback,
	output port_pkg::operand_t operands
);

	reg_pkg::scalar_t scalar1;	// Raw scalar reads, possibly stale
	reg_pkg::scalar_t scalar2;
	reg_pkg::vector_word_u vector1;	// Raw vector reads, possibly stale
	reg_pkg::vector_word_u vector2;

	// Each file filters writebacks by kind
	scalar_register_file i_scalar_register_file (
		.clk		(clk),
		.strand		(read_req.strand),
		.sel1		(read_req.sel1),
		.sel2		(read_req.sel2),
		.writeback	(writeback),
		.value1		(scalar1),
		.value2		(scalar2)
	);

	vector_register_file i_vector_register_file (
		.clk		(clk),
		.strand		(read_req.strand),
		.sel1		(read_req.sel1),
		.sel2		(read_req.sel2),
		.writeback	(writeback),
		.value1		(vector1),
		.value2		(vector2)
	);

	operand_bypass i_operand_bypass (
		.clk		(clk),
		.reset		(reset),
		.read_req	(read_req),
		.writeback	(writeback),
		.scalar1	(scalar1),
		.scalar2	(scalar2),
		.vector1	(vector1),
		.vector2	(vector2),
		.operands	(operands)
	);

endmodule

// File: dv/operand_checker.sv
//////////////////////////////////////////////////
// Operand checker
// Register state model that predicts each operand
// result and compares it with the DUT output
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "pipeline_consts.svh"

module operand_checker
(
	input logic clk,
	input logic reset,
	input port_pkg::read_req_t read_req,
	input port_pkg::writeback_t writeback,
	input port_pkg::operand_t operands,
	input logic [159:0] test_name,	// Up to 20 characters
	output int checks_passed,
	output int checks_failed
);

	reg_pkg::scalar_t scalar_model[`NUM_STRANDS*`REGS_PER_STRAND];
	reg_pkg::vector_word_u vector_model[`NUM_STRANDS*`REGS_PER_STRAND];

	logic pending_valid;	// Result due at the next edge
	logic [159:0] pending_name;
	reg_pkg::vector_word_u expected_op1;
	reg_pkg::vector_word_u expected_op2;

	// Operand as the register state defines it
	function automatic reg_pkg::vector_word_u model_operand(input logic is_vector,
		input reg_pkg::strand_t strand, input reg_pkg::reg_index_t index);
		reg_pkg::reg_addr_t addr;
		reg_pkg::vector_word_u word;

		addr.strand = strand;
		addr.index = index;
		if (is_vector)
			word = vector_model[addr];
		else
			for (int lane = 0; lane < `NUM_LANES; lane++)
				word.lanes[lane] = scalar_model[addr];	// Same scalar in each lane
		return word;
	endfunction

	always @(posedge clk)
	begin
		if (reset)
		begin
			checks_passed = 0;
			checks_failed = 0;
		end
		else if (pending_valid && operands.valid !== 1'b1)
		begin
			$display("Missing operands valid one cycle after request %0s", pending_name);
			checks_failed++;
		end
		else if (!pending_valid && operands.valid !== 1'b0)
		begin
			$display("Unexpected operands valid with no request in the previous cycle");
			checks_failed++;
		end
		else if (pending_valid)
		begin
			if (operands.op1 !== expected_op1)
			begin
				$display("Fail %0s op1 expected %h actual %h", pending_name,
					expected_op1, operands.op1);
				checks_failed++;
			end
			else if (operands.op2 !== expected_op2)
			begin
				$display("Fail %0s op2 expected %h actual %h", pending_name,
					expected_op2, operands.op2);
				checks_failed++;
			end
			else
			begin
				$display("Pass %0s", pending_name);
				checks_passed++;
			end
		end

		// Writes at this edge are visible to a read at this edge
		if (writeback.valid === 1'b1)
		begin
			if (writeback.is_vector)
			begin
				for (int lane = 0; lane < `NUM_LANES; lane++)
					if (writeback.mask[lane])
						vector_model[writeback.addr].lanes[lane] = writeback.value.lanes[lane];
			end
			else
				scalar_model[writeback.addr] = writeback.value.lanes[0];
		end

		pending_valid = !reset && read_req.valid === 1'b1;
		pending_name = test_name;
		expected_op1 = model_operand(read_req.op1_is_vector, read_req.strand, read_req.sel1);
		expected_op2 = model_operand(read_req.op2_is_vector, read_req.strand, read_req.sel2);
	end

endmodule

// File: dv/tb_register_operand_unit.sv
//////////////////////////////////////////////////
// Register operand unit testbench
// Preloads both files, then applies a table of
// writebacks and read requests on falling edges
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "pipeline_consts.svh"

module tb_register_operand_unit;

	localparam int RESET_CYCLES = 2;
	localparam int MAX_STEPS = 32;

	// One table row, applied for one cycle
	typedef struct packed
	{
		logic [159:0] name;
		port_pkg::writeback_t wb;
		port_pkg::read_req_t req;
	} step_t;

	logic clk;
	logic reset;
	port_pkg::read_req_t read_req;
	port_pkg::writeback_t writeback;
	port_pkg::operand_t operands;
	logic [159:0] test_name;
	int checks_passed;
	int checks_failed;

	step_t steps[MAX_STEPS];
	int step_count;
	int read_count;	// Results expected from the checker
	int cycle_count = 0;
	int cycle_limit;

	register_operand_unit i_dut (
		.clk		(clk),
		.reset		(reset),
		.read_req	(read_req),
		.writeback	(writeback),
		.operands	(operands)
	);

	operand_checker i_checker (
		.clk			(clk),
		.reset			(reset),
		.read_req		(read_req),
		.writeback		(writeback),
		.operands		(operands),
		.test_name		(test_name),
		.checks_passed	(checks_passed),
		.checks_failed	(checks_failed)
	);

	always #50 clk = ~clk;	// 100 ns period

	function automatic reg_pkg::vector_word_u random_vector();
		reg_pkg::vector_word_u word;

		for (int lane = 0; lane < `NUM_LANES; lane++)
			word.lanes[lane] = $urandom();
		return word;
	endfunction

	// Upper lanes and mask are random junk that a scalar write ignores
	function automatic port_pkg::writeback_t scalar_write(input reg_pkg::strand_t strand,
		input reg_pkg::reg_index_t index);
		port_pkg::writeback_t wb;

		wb.valid = 1'b1;
		wb.is_vector = 1'b0;
		wb.addr.strand = strand;
		wb.addr.index = index;
		wb.value = random_vector();
		wb.mask = reg_pkg::lane_mask_t'($urandom());
		return wb;
	endfunction

	function automatic port_pkg::writeback_t vector_write(input reg_pkg::strand_t strand,
		input reg_pkg::reg_index_t index, input logic full_mask);
		port_pkg::writeback_t wb;

		wb.valid = 1'b1;
		wb.is_vector = 1'b1;
		wb.addr.strand = strand;
		wb.addr.index = index;
		wb.value = random_vector();
		wb.mask = full_mask ? '1 : reg_pkg::lane_mask_t'($urandom());
		return wb;
	endfunction

	function automatic port_pkg::read_req_t read_request(input reg_pkg::strand_t strand,
		input reg_pkg::reg_index_t sel1, input reg_pkg::reg_index_t sel2,
		input logic op1_is_vector, input logic op2_is_vector);
		port_pkg::read_req_t req;

		req.valid = 1'b1;
		req.strand = strand;
		req.sel1 = sel1;
		req.sel2 = sel2;
		req.op1_is_vector = op1_is_vector;
		req.op2_is_vector = op2_is_vector;
		return req;
	endfunction

	task automatic add_step(input logic [159:0] name, input port_pkg::writeback_t wb,
		input port_pkg::read_req_t req);
		steps[step_count] = '{name: name, wb: wb, req: req};
		step_count++;
		if (req.valid)
			read_count++;
	endtask

	task automatic build_table();
		add_step("preload_s0_r1", scalar_write(0, 1), '0);	// Every read register written first
		add_step("preload_s0_r2", scalar_write(0, 2), '0);
		add_step("preload_s1_r1", scalar_write(1, 1), '0);
		add_step("preload_s0_v1", vector_write(0, 1, 1'b1), '0);
		add_step("preload_s0_v2", vector_write(0, 2, 1'b1), '0);
		add_step("preload_s0_v3", vector_write(0, 3, 1'b1), '0);
		add_step("preload_s2_v1", vector_write(2, 1, 1'b1), '0);
		add_step("scalar_pair", '0, read_request(0, 1, 2, 1'b0, 1'b0));
		add_step("strand_pair", '0, read_request(1, 1, 1, 1'b0, 1'b0));	// Back to back
		add_step("vector_pair", '0, read_request(0, 1, 2, 1'b1, 1'b1));
		add_step("masked_write", vector_write(0, 3, 1'b0), '0);
		add_step("masked_read", '0, read_request(0, 3, 3, 1'b1, 1'b1));
		add_step("scalar_bypass", scalar_write(0, 5), read_request(0, 5, 1, 1'b0, 1'b0));
		add_step("vector_bypass", vector_write(0, 2, 1'b0), read_request(0, 2, 1, 1'b1, 1'b1));
		add_step("mixed_v_s", '0, read_request(0, 1, 2, 1'b1, 1'b0));
		add_step("mixed_s_v", '0, read_request(0, 2, 1, 1'b0, 1'b1));
		add_step("kind_scalar", scalar_write(0, 3), read_request(0, 3, 3, 1'b1, 1'b1));
		add_step("kind_vector", vector_write(0, 2, 1'b0), read_request(0, 2, 2, 1'b0, 1'b1));
		add_step("strand_write", scalar_write(2, 1), read_request(1, 1, 1, 1'b0, 1'b0));
		add_step("strand_read", '0, read_request(2, 1, 1, 1'b0, 1'b1));
		add_step("strand_other", '0, read_request(0, 1, 2, 1'b0, 1'b0));
	endtask

	// Run limit from the table length
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count > cycle_limit)
		begin
			$display("Timeout after %0d cycles with %0d of %0d results checked",
				cycle_count, checks_passed + checks_failed, read_count);
			$display("Testbench failed");
			$finish;
		end
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		read_req = read_request(0, 1, 2, 1'b0, 1'b0);	// Held through reset, gives no result
		writeback = '0;
		test_name = '0;
		step_count = 0;
		read_count = 0;
		cycle_limit = 0;
		void'($urandom(5546));
		build_table();
		cycle_limit = step_count + RESET_CYCLES + 20;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;	// Idle cycle follows, valid must stay low
		read_req = '0;

		for (int i = 0; i < step_count; i++)
		begin
			@(negedge clk);
			test_name = steps[i].name;
			writeback = steps[i].wb;
			read_req = steps[i].req;
		end
		@(negedge clk);
		test_name = '0;
		writeback = '0;
		read_req = '0;

		// Last result lands one cycle after its request
		while (checks_passed + checks_failed < read_count)
			@(negedge clk);
		@(negedge clk);

		$display("Checks: %0d passed, %0d failed, %0d expected", checks_passed,
			checks_failed, read_count);
		if (checks_failed == 0 && checks_passed == read_count)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: project.f
+incdir+include
src/reg_pkg.sv
src/port_pkg.sv
src/scalar_register_file.sv
src/vector_register_file.sv
src/operand_bypass.sv
src/register_operand_unit.sv
dv/operand_checker.sv
dv/tb_register_operand_unit.sv

// File: Bender.yml
package:
  name: register_operand_unit

# Design sources in compile order
sources:
  - include_dirs:
      - include
    files:
      - src/reg_pkg.sv
      - src/port_pkg.sv
      - src/scalar_register_file.sv
      - src/vector_register_file.sv
      - src/operand_bypass.sv
      - src/register_operand_unit.sv

  # Testbench with its checker
  - target: test
    include_dirs:
      - include
    files:
      - dv/operand_checker.sv
      - dv/tb_register_operand_unit.sv

export_include_dirs:
  - include
